//--- common/audio_pkg.sv
package audio_pkg;

	// One signed channel sample as used by the codec stream
	typedef logic signed [31:0] sample_t;

	// Left and right channel of one stereo frame
	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_sample_t;

	localparam sample_t TONE_AMP = 32'sd10000000; // Square-wave amplitude
	localparam sample_t SILENCE = 32'sd0; // Offset while the tone is muted

	// Signed offset of the square wave for one phase
	function automatic sample_t tone_offset(logic enable, logic phase);
		sample_t offset;
		if (!enable) begin
			offset = SILENCE;
		end else if (phase) begin
			offset = TONE_AMP; // High half of the wave
		end else begin
			offset = -TONE_AMP; // Low half of the wave
		end
		return offset;
	endfunction

	// Same offset on both channels, wrapping at 32 bits
	function automatic stereo_sample_t add_offset(stereo_sample_t frame, sample_t offset);
		stereo_sample_t mixed;
		mixed.left = frame.left + offset;
		mixed.right = frame.right + offset;
		return mixed;
	endfunction

endpackage

//--- common/music_pkg.sv
package music_pkg;

	// Pitch code as stored in the note table
	typedef logic [7:0] note_t;

	// Address into the note table
	typedef logic [5:0] melody_addr_t;

	// Song section, each with its own tempo
	typedef logic section_t;

	// Beat limit in clock cycles
	typedef logic [31:0] beat_len_t;

	localparam int MELODY_DEPTH = 48; // Entries in the note table
	localparam melody_addr_t LAST_ADDR = melody_addr_t'(MELODY_DEPTH - 1);
	localparam melody_addr_t SECTION1_START = melody_addr_t'(28); // First note of song two

	localparam section_t SECTION_0 = 1'b0;
	localparam section_t SECTION_1 = 1'b1;

	localparam note_t NOTE_REST = 8'd0; // Value before the first table read

	localparam beat_len_t BEAT_80BPM = 32'd37593984; // Section 0 at 50 MHz
	localparam beat_len_t BEAT_150BPM = 32'd20000000; // Section 1 at 50 MHz

	// Pitch table, path seen from the project root
	localparam string MELODY_FILE = "melody/melody.hex";

	// Section that a note address belongs to
	function automatic section_t section_of(melody_addr_t addr);
		section_t section;
		section = (addr >= SECTION1_START) ? SECTION_1 : SECTION_0;
		return section;
	endfunction

	// Beat limit of a section after the tempo divisor
	function automatic beat_len_t beat_limit(section_t section, int unsigned div);
		beat_len_t full_limit;
		if (section == SECTION_1) begin
			full_limit = BEAT_150BPM;
		end else begin
			full_limit = BEAT_80BPM;
		end
		return beat_len_t'(full_limit / div);
	endfunction

endpackage

//--- design/music_player.sv
`timescale 1ns/10ps

module music_player #(
	parameter int TEMPO_DIV = 1, // Divides both beat limits
	parameter int TONE_SHIFT = 11, // Note code position in the half-period
	parameter int TONE_LOW = 952 // Fixed low bits of the half-period
) (
	input logic CLOCK_50,
	input logic rst,
	input logic tone_enable,
	input logic in_available,
	input logic out_allowed,
	input audio_pkg::stereo_sample_t sample_in,
	output audio_pkg::stereo_sample_t sample_out,
	output logic transfer
);
	import music_pkg::*;

	melody_addr_t addr; // Current note address
	note_t note; // Pitch code of that address
	logic phase; // Square-wave level

	// Steps through the melody, one address per beat
	song_sequencer #(
		.TEMPO_DIV(TEMPO_DIV)
	) song_sequencer_i (
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.addr(addr)
	);

	// Address to pitch code, one cycle later
	melody_rom melody_rom_i (
		.CLOCK_50(CLOCK_50),
		.addr(addr),
		.note(note)
	);

	// Pitch code to square wave
	tone_oscillator #(
		.TONE_SHIFT(TONE_SHIFT),
		.TONE_LOW(TONE_LOW)
	) tone_oscillator_i (
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.note(note),
		.phase(phase)
	);

	// Square wave into the codec stream
	sample_mixer sample_mixer_i (
		.tone_enable(tone_enable),
		.phase(phase),
		.in_available(in_available),
		.out_allowed(out_allowed),
		.sample_in(sample_in),
		.sample_out(sample_out),
		.transfer(transfer)
	);

endmodule

//--- design/sample_mixer.sv
`timescale 1ns/10ps

module sample_mixer (
	input logic tone_enable,
	input logic phase,
	input logic in_available,
	input logic out_allowed,
	input audio_pkg::stereo_sample_t sample_in,
	output audio_pkg::stereo_sample_t sample_out,
	output logic transfer
);
	import audio_pkg::*;

	sample_t offset; // Signed tone level for this cycle

	// Zero while muted, otherwise plus or minus the amplitude
	assign offset = tone_offset(tone_enable, phase);

	// Tone rides on top of the incoming audio, same on both channels
	assign sample_out = add_offset(sample_in, offset);

	// Codec reads and writes together, only when both sides are ready
	assign transfer = in_available & out_allowed;

endmodule

//--- design/tone_oscillator.sv
`timescale 1ns/10ps

module tone_oscillator #(
	parameter int TONE_SHIFT = 11, // Note code position in the half-period
	parameter int TONE_LOW = 952 // Fixed low bits of the half-period
) (
	input logic CLOCK_50,
	input logic rst,
	input music_pkg::note_t note,
	output logic phase
);
	import music_pkg::*;

	// Half-period holds the note code above TONE_SHIFT fixed bits
	localparam int HALF_W = $bits(note_t) + TONE_SHIFT;

	typedef logic [HALF_W-1:0] half_t;

	localparam half_t LOW_MASK = (half_t'(1) << TONE_SHIFT) - half_t'(1);
	localparam half_t LOW_BITS = half_t'(TONE_LOW) & LOW_MASK;

	half_t half_period; // Cycles per half wave, minus one
	half_t half_cnt; // Cycles into the current half wave
	logic phase_q; // Square-wave level
	logic half_end; // Last cycle of the half wave

	// Higher code gives a longer period, so a lower pitch
	assign half_period = (half_t'(note) << TONE_SHIFT) | LOW_BITS;

	assign half_end = (half_cnt == half_period);

	// A new note is picked up at the next compare
	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			half_cnt <= '0;
			phase_q <= 1'b0;
		end else if (half_end) begin
			half_cnt <= '0;
			phase_q <= ~phase_q; // Flip the wave
		end else begin
			half_cnt <= half_cnt + 1'b1;
		end
	end

	assign phase = phase_q;

endmodule

//--- melody/melody.hex
// One pitch code per line in hex, address 0 first
// Addresses 0 to 27 are section 0, 28 to 47 are section 1
0c
0a
09
0a
0c
0c
0c
0a
0a
0a
0c
08
08
0c
0a
09
0a
0c
0c
0c
0c
0a
0a
0c
0a
09
0b
0c
06
06
04
04
03
03
04
05
05
06
06
07
07
06
04
04
05
05
06
07

//--- melody/melody_rom.sv
`timescale 1ns/10ps

module melody_rom (
	input logic CLOCK_50,
	input music_pkg::melody_addr_t addr,
	output music_pkg::note_t note
);
	import music_pkg::*;

	// Pitch codes of both songs, section 0 first
	note_t mem [MELODY_DEPTH];

	note_t note_q = NOTE_REST; // Reads as a rest until the first clock

	initial begin
		$readmemh(MELODY_FILE, mem);
	end

	// Registered read, maps to block RAM
	always_ff @(posedge CLOCK_50) begin
		note_q <= mem[addr];
	end

	assign note = note_q;

endmodule

//--- melody/song_sequencer.sv
`timescale 1ns/10ps

module song_sequencer #(
	parameter int TEMPO_DIV = 1 // Divides both beat limits
) (
	input logic CLOCK_50,
	input logic rst,
	output music_pkg::melody_addr_t addr
);
	import music_pkg::*;

	// Beat limits of both sections, fixed at elaboration
	localparam beat_len_t LIMIT_S0 = beat_limit(SECTION_0, TEMPO_DIV);
	localparam beat_len_t LIMIT_S1 = beat_limit(SECTION_1, TEMPO_DIV);

	melody_addr_t addr_q; // Note being played
	melody_addr_t next_addr; // Note of the next beat
	beat_len_t beat_cnt; // Cycles into the current beat
	beat_len_t cur_limit; // Limit of the current section
	section_t section; // Section of the current note
	logic beat_end; // Last cycle of the beat

	// The tempo follows the section of the note being played,
	// so the switch to 150 bpm happens with the first note of song two
	always_comb begin
		section = section_of(addr_q);
		if (section == SECTION_1) begin
			cur_limit = LIMIT_S1;
		end else begin
			cur_limit = LIMIT_S0;
		end
	end

	assign beat_end = (beat_cnt == cur_limit); // Beat lasts cur_limit+1 cycles

	// Back to the start after the last beat of the last note
	always_comb begin
		if (addr_q == LAST_ADDR) begin
			next_addr = '0;
		end else begin
			next_addr = addr_q + 1'b1;
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			beat_cnt <= '0;
			addr_q <= '0;
		end else if (beat_end) begin
			beat_cnt <= '0; // Start of a new beat
			addr_q <= next_addr;
		end else begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	assign addr = addr_q;

endmodule

//--- project.f
common/music_pkg.sv
common/audio_pkg.sv
melody/song_sequencer.sv
melody/melody_rom.sv
design/tone_oscillator.sv
design/sample_mixer.sv
design/music_player.sv
verification/music_player_assert.sv
verification/tb_music_player.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_music_player \
	-f project.f

sim_out=$(./obj_dir/Vtb_music_player 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "test passed"; then
	exit 0
else
	exit 1
fi

//--- verification/music_player_assert.sv
`timescale 1ns/10ps

module music_player_assert (
	input logic CLOCK_50,
	input logic rst,
	input logic tone_enable,
	input logic in_available,
	input logic out_allowed,
	input audio_pkg::stereo_sample_t sample_in,
	input audio_pkg::stereo_sample_t sample_out,
	input logic transfer,
	input music_pkg::melody_addr_t addr
);
	import music_pkg::*;

	// Strobe is a plain AND, reset or not
	transfer_is_and: assert property (@(posedge CLOCK_50)
		transfer == (in_available & out_allowed))
		else $error("transfer is not in_available AND out_allowed");

	mute_passes_through: assert property (@(posedge CLOCK_50)
		!tone_enable |-> (sample_out == sample_in))
		else $error("sample_out differs from sample_in while the tone is muted");

	addr_in_range: assert property (@(posedge CLOCK_50) disable iff (rst)
		addr <= LAST_ADDR)
		else $error("note address is past the last melody entry");

endmodule

bind music_player music_player_assert music_player_assert_i (.*);

//--- verification/tb_music_player.sv
`timescale 1ns/10ps

module tb_music_player;
	import music_pkg::*;
	import audio_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 4;
	localparam int TEMPO_DIV = 1000000;
	localparam int TONE_SHIFT = 2;
	localparam int TONE_LOW = 1;
	localparam int HALF_W = $bits(note_t) + TONE_SHIFT;

	localparam beat_len_t LIMIT0 = beat_len_t'(BEAT_80BPM / TEMPO_DIV); // 37 here
	localparam beat_len_t LIMIT1 = beat_len_t'(BEAT_150BPM / TEMPO_DIV); // 20 here
	localparam int PASS_CYCLES = int'(SECTION1_START) * int'(LIMIT0 + 1)
		+ (MELODY_DEPTH - int'(SECTION1_START)) * int'(LIMIT1 + 1);
	localparam int RUN_CYCLES = 2 * PASS_CYCLES; // Two full passes of the melody
	localparam int TIMEOUT_NS = 3 * (RUN_CYCLES + RESET_CYCLES) * CLK_PERIOD;

	typedef logic [HALF_W-1:0] half_t;

	logic CLOCK_50;
	logic rst;
	logic tone_enable;
	logic in_available;
	logic out_allowed;
	stereo_sample_t sample_in;
	stereo_sample_t sample_out;
	logic transfer;

	integer seed;
	integer rnd;
	int run_left; // Cycles left in the current tone_enable run

	// Reference model state
	note_t rom_model [MELODY_DEPTH];
	melody_addr_t m_addr;
	beat_len_t m_beat;
	note_t m_note;
	half_t m_cnt;
	logic m_phase;
	sample_t offset;
	stereo_sample_t expected;

	music_player #(
		.TEMPO_DIV(TEMPO_DIV),
		.TONE_SHIFT(TONE_SHIFT),
		.TONE_LOW(TONE_LOW)
	) music_player_i (
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.tone_enable(tone_enable),
		.in_available(in_available),
		.out_allowed(out_allowed),
		.sample_in(sample_in),
		.sample_out(sample_out),
		.transfer(transfer)
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Simulation timed out before the melody finished two passes");
		$display("test failed");
		$fatal(1, "watchdog expired");
	end

	// One clock edge of sequencer, ROM and oscillator
	task automatic step_model(input logic in_reset);
		note_t next_note;
		half_t half;
		beat_len_t limit;
		next_note = rom_model[m_addr]; // ROM has no reset
		half = (half_t'(m_note) << TONE_SHIFT) | half_t'(TONE_LOW);
		limit = (m_addr >= SECTION1_START) ? LIMIT1 : LIMIT0;
		if (in_reset) begin
			m_beat = '0;
			m_addr = '0;
			m_cnt = '0;
			m_phase = 1'b0;
		end else begin
			if (m_cnt == half) begin
				m_cnt = '0;
				m_phase = ~m_phase;
			end else begin
				m_cnt = m_cnt + half_t'(1);
			end
			if (m_beat == limit) begin
				m_beat = '0;
				if (m_addr == LAST_ADDR) begin
					m_addr = '0;
				end else begin
					m_addr = m_addr + melody_addr_t'(1);
				end
			end else begin
				m_beat = m_beat + beat_len_t'(1);
			end
		end
		m_note = next_note;
	endtask

	task automatic drive_inputs();
		if (run_left == 0) begin
			run_left = 10 + ($unsigned($random(seed)) % 31); // 10 to 40 cycles
			tone_enable <= ~tone_enable;
		end
		run_left = run_left - 1;
		rnd = $random(seed);
		in_available <= rnd[0];
		out_allowed <= rnd[5];
		sample_in.left <= $random(seed);
		sample_in.right <= $random(seed);
	endtask

	task automatic check_sample(input stereo_sample_t actual, input stereo_sample_t exp_val,
		input int cycle);
		if (actual.left !== exp_val.left) begin
			$display("MISMATCH sample_out.left cycle %0d: got %h, expected %h",
				cycle, actual.left, exp_val.left);
			$display("test failed");
			$fatal(1, "left channel error");
		end
		if (actual.right !== exp_val.right) begin
			$display("MISMATCH sample_out.right cycle %0d: got %h, expected %h",
				cycle, actual.right, exp_val.right);
			$display("test failed");
			$fatal(1, "right channel error");
		end
	endtask

	task automatic check_strobe(input logic actual, input logic exp_val, input int cycle);
		if (actual !== exp_val) begin
			$display("MISMATCH transfer cycle %0d: got %h, expected %h", cycle, actual, exp_val);
			$display("test failed");
			$fatal(1, "strobe error");
		end
	endtask

	initial begin
		seed = 58;
		rst = 1'b1;
		tone_enable = 1'b0;
		in_available = 1'b0;
		out_allowed = 1'b0;
		sample_in = '0;
		run_left = 0;
		m_addr = '0;
		m_beat = '0;
		m_note = 8'h00; // Note reads as 0 before the first read
		m_cnt = '0;
		m_phase = 1'b0;
		$readmemh("melody/melody.hex", rom_model);

		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge CLOCK_50);
			step_model(1'b1);
		end
		rst <= 1'b0;

		for (int cycle = 0; cycle < RUN_CYCLES; cycle++) begin
			@(posedge CLOCK_50);
			step_model(1'b0);
			drive_inputs();
			@(negedge CLOCK_50); // Outputs settled
			if (!tone_enable) begin
				offset = '0;
			end else if (m_phase) begin
				offset = TONE_AMP;
			end else begin
				offset = -TONE_AMP;
			end
			expected.left = sample_in.left + offset;
			expected.right = sample_in.right + offset;
			check_sample(sample_out, expected, cycle);
			check_strobe(transfer, in_available & out_allowed, cycle);
		end

		$display("test passed");
		$finish;
	end

endmodule
